//--- Bender.yml
package:
  name: ddr_ctrl

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/ddr_ctrl_pkg.sv
      - source/ddr_delay_counter.sv
      - source/ddr_cmd_fsm.sv
      - source/ddr_bank_memory.sv
      - source/ddr_ctrl_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - bench/ddr_ctrl_tb.sv

//--- bench/ddr_ctrl_tb.sv
`timescale 1ns/10ps
`include "ddr_ctrl_macros.svh"

module ddr_ctrl_tb;
    import ddr_ctrl_pkg::*;

    localparam int INIT_CYCLES  = `T_PWR_UP + `T_PRECHARGE + `T_REFRESH;
    localparam int READ_CYCLES  = `T_RCD + `T_CAS; // accept to rd_valid
    localparam int WRITE_CYCLES = `T_RCD + `T_WR;  // accept to ready
    localparam int TIMEOUT      = 200;
    localparam int NUM_RANDOM   = 200;
    localparam int SHADOW_W     = `MEM_BANK_BITS + `MEM_ROW_BITS + `DDR_COL_W;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cpu_rd;
    logic       cpu_wr;
    bank_addr_t cpu_bank;
    row_addr_t  cpu_row;
    col_addr_t  cpu_col;
    ddr_data_t  cpu_wdata;
    ddr_data_t  cpu_rdata;
    logic       rd_valid;
    logic       ready;

    ddr_data_t            shadow [2**SHADOW_W] = '{default: '0};
    ddr_data_t            pending [$];  // expected data of reads in flight
    logic [SHADOW_W-1:0]  written [$];
    int                   reads_checked = 0;

    ddr_ctrl_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_rd    (cpu_rd),
        .cpu_wr    (cpu_wr),
        .cpu_bank  (cpu_bank),
        .cpu_row   (cpu_row),
        .cpu_col   (cpu_col),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .rd_valid  (rd_valid),
        .ready     (ready)
    );

    always #50 clk = ~clk;

    // low bank and row bits together with the whole column select a word
    function automatic logic [SHADOW_W-1:0] shadow_index(input bank_addr_t bank,
                                                         input row_addr_t row,
                                                         input col_addr_t col);
        return {bank[`MEM_BANK_BITS-1:0], row[`MEM_ROW_BITS-1:0], col};
    endfunction

    function automatic ddr_data_t expected_read(input bank_addr_t bank,
                                                input row_addr_t row,
                                                input col_addr_t col);
        return shadow[shadow_index(bank, row, col)];
    endfunction

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s mismatch, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s never arrived within %0d cycles", $time, what, TIMEOUT);
        stop_with_failure();
    endtask

    // one access from request to ready while the controller is idle
    task automatic do_access(input logic rd, input logic wr, input bank_addr_t bank,
                             input row_addr_t row, input col_addr_t col,
                             input ddr_data_t data, input bit scramble,
                             input bit busy_pulse);
        int n;
        @(posedge clk);
        cpu_rd    <= rd;
        cpu_wr    <= wr;
        cpu_bank  <= bank;
        cpu_row   <= row;
        cpu_col   <= col;
        cpu_wdata <= data;
        @(posedge clk); // request taken on this edge
        cpu_rd <= 1'b0;
        cpu_wr <= 1'b0;
        if (scramble) begin
            cpu_bank  <= bank_addr_t'($urandom);
            cpu_row   <= row_addr_t'($urandom);
            cpu_col   <= col_addr_t'($urandom);
            cpu_wdata <= ~data;
        end
        if (rd) begin
            pending.push_back(expected_read(bank, row, col));
        end else begin
            shadow[shadow_index(bank, row, col)] = data;
            written.push_back(shadow_index(bank, row, col));
        end
        n = 0;
        if (busy_pulse) begin
            // same address with other data while the controller is busy
            @(posedge clk);
            cpu_rd    <= rd;
            cpu_wr    <= 1'b1;
            cpu_wdata <= ~data;
            @(posedge clk);
            cpu_rd <= 1'b0;
            cpu_wr <= 1'b0;
            n = 2;
        end
        @(negedge clk);
        if (rd) begin
            while (!rd_valid && n < TIMEOUT) begin
                @(posedge clk);
                n++;
                @(negedge clk);
            end
            if (!rd_valid) begin
                report_timeout("rd_valid");
            end
            check_value(n, READ_CYCLES, "rd_valid latency");
        end
        while (!ready && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        if (!ready) begin
            report_timeout("ready");
        end
        check_value(n, rd ? READ_CYCLES + 1 : WRITE_CYCLES, "ready latency");
    endtask

    // every returned word against the shadow value taken at acceptance
    always @(negedge clk) begin
        if (rst_n && rd_valid) begin
            if (pending.size() == 0) begin
                $display("rd_valid pulsed at %0t with no read outstanding", $time);
                stop_with_failure();
            end else begin
                check_value(cpu_rdata, pending.pop_front(), "read data");
                reads_checked++;
            end
        end
    end

    initial begin
        int                  n;
        logic                is_read;
        bank_addr_t          bank;
        row_addr_t           row;
        col_addr_t           col;
        ddr_data_t           data;
        logic [SHADOW_W-1:0] pick;
        void'($urandom(32'hbf9d8f62));
        rst_n     = 1'b0;
        cpu_rd    = 1'b0;
        cpu_wr    = 1'b0;
        cpu_bank  = '0;
        cpu_row   = '0;
        cpu_col   = '0;
        cpu_wdata = '0;

        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value(ready, 1'b0, "ready during reset");
            check_value(rd_valid, 1'b0, "rd_valid during reset");
            check_value(cpu_rdata, '0, "cpu_rdata during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!ready && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        if (!ready) begin
            report_timeout("ready after reset");
        end
        check_value(n, INIT_CYCLES, "init latency");

        // write and read back through aliased high bits and an empty word
        do_access(1'b0, 1'b1, 4'h5, 16'h1234, 8'h3c, 32'hdeadbeef, 1'b0, 1'b0);
        do_access(1'b1, 1'b0, 4'h5, 16'h1234, 8'h3c, '0, 1'b0, 1'b0);
        do_access(1'b1, 1'b0, 4'hd, 16'hfff4, 8'h3c, '0, 1'b0, 1'b0);
        do_access(1'b1, 1'b0, 4'h2, 16'h0007, 8'h81, '0, 1'b0, 1'b0);

        // read wins and the write data must not land
        do_access(1'b1, 1'b1, 4'h5, 16'h1234, 8'h3c, 32'h0badf00d, 1'b0, 1'b0);
        do_access(1'b1, 1'b0, 4'h5, 16'h1234, 8'h3c, '0, 1'b0, 1'b0);

        // requests while busy are dropped
        do_access(1'b0, 1'b1, 4'h3, 16'h00a9, 8'h10, 32'h5a5a1234, 1'b0, 1'b1);
        do_access(1'b1, 1'b0, 4'h3, 16'h00a9, 8'h10, '0, 1'b0, 1'b1);
        do_access(1'b1, 1'b0, 4'h3, 16'h00a9, 8'h10, '0, 1'b0, 1'b0);

        // inputs change right after acceptance
        do_access(1'b0, 1'b1, 4'h6, 16'h4321, 8'hf0, 32'hcafe0042, 1'b1, 1'b0);
        do_access(1'b1, 1'b0, 4'h6, 16'h4321, 8'hf0, '0, 1'b0, 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            is_read = logic'($urandom_range(0, 1));
            bank    = bank_addr_t'($urandom);
            row     = row_addr_t'($urandom);
            col     = col_addr_t'($urandom);
            data    = ddr_data_t'($urandom);
            if (is_read && written.size() > 0 && $urandom_range(0, 1) == 1) begin
                // revisit a written word with random high bits
                pick = written[$urandom_range(0, written.size() - 1)];
                bank[`MEM_BANK_BITS-1:0] = pick[SHADOW_W-1 -: `MEM_BANK_BITS];
                row[`MEM_ROW_BITS-1:0]   = pick[`DDR_COL_W +: `MEM_ROW_BITS];
                col                      = pick[`DDR_COL_W-1:0];
            end
            do_access(is_read, !is_read, bank, row, col, data, 1'b0, 1'b0);
        end

        if (pending.size() != 0) begin
            $display("%0d reads never returned data", pending.size());
            stop_with_failure();
        end else begin
            $display("reads checked: %0d", reads_checked);
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+source
source/ddr_ctrl_pkg.sv
source/ddr_delay_counter.sv
source/ddr_cmd_fsm.sv
source/ddr_bank_memory.sv
source/ddr_ctrl_top.sv
bench/ddr_ctrl_tb.sv

//--- source/ddr_bank_memory.sv
`timescale 1ns/10ps
`include "ddr_ctrl_macros.svh"

module ddr_bank_memory #(
    parameter int BANK_BITS = `MEM_BANK_BITS,
    parameter int ROW_BITS  = `MEM_ROW_BITS
) (
    input  logic                     clk,
    input  logic                     active,
    input  ddr_ctrl_pkg::bank_addr_t ddr_bank,
    input  ddr_ctrl_pkg::row_addr_t  ddr_row,
    input  ddr_ctrl_pkg::col_addr_t  ddr_col,
    input  logic                     ddr_read,
    input  logic                     ddr_write,
    input  ddr_ctrl_pkg::ddr_data_t  ddr_write_data,
    output ddr_ctrl_pkg::ddr_data_t  ddr_read_data
);
    import ddr_ctrl_pkg::*;

    localparam int ADDR_W = BANK_BITS + ROW_BITS + `DDR_COL_W;
    localparam int DEPTH  = 2 ** ADDR_W;

    // high bank and row bits alias onto the kept low bits
    ddr_data_t mem [DEPTH] = '{default: '0};

    logic [BANK_BITS-1:0] open_bank;
    logic [ROW_BITS-1:0]  open_row;
    logic [ADDR_W-1:0]    index;

    // row stays open until the next activate
    always_ff @(posedge clk) begin
        if (active) begin
            open_bank <= ddr_bank[BANK_BITS-1:0];
            open_row  <= ddr_row[ROW_BITS-1:0];
        end
    end

    assign index = {open_bank, open_row, ddr_col};

    always_ff @(posedge clk) begin
        if (ddr_write) begin
            mem[index] <= ddr_write_data; // same word every cycle of the strobe
        end
    end

    assign ddr_read_data = ddr_read ? mem[index] : '0;

endmodule

//--- source/ddr_cmd_fsm.sv
`timescale 1ns/10ps
`include "ddr_ctrl_macros.svh"

module ddr_cmd_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cpu_rd,
    input  logic                     cpu_wr,
    input  ddr_ctrl_pkg::bank_addr_t cpu_bank,
    input  ddr_ctrl_pkg::row_addr_t  cpu_row,
    input  ddr_ctrl_pkg::col_addr_t  cpu_col,
    input  ddr_ctrl_pkg::ddr_data_t  cpu_wdata,
    output ddr_ctrl_pkg::ddr_data_t  cpu_rdata,
    output logic                     rd_valid,
    output logic                     ready,
    input  logic                     count_done,
    output logic                     count_start,
    output ddr_ctrl_pkg::delay_cnt_t count_value,
    output logic                     active,
    output logic                     ddr_read,
    output logic                     ddr_write,
    output ddr_ctrl_pkg::bank_addr_t ddr_bank,
    output ddr_ctrl_pkg::row_addr_t  ddr_row,
    output ddr_ctrl_pkg::col_addr_t  ddr_col,
    output ddr_ctrl_pkg::ddr_data_t  ddr_write_data,
    input  ddr_ctrl_pkg::ddr_data_t  ddr_read_data
);
    import ddr_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    delay_cnt_t  entry_delay;   // wait of the next state or zero when untimed
    logic        entering;
    logic        pwr_up_loaded;
    logic        accept;

    bank_addr_t  req_bank;
    row_addr_t   req_row;
    col_addr_t   req_col;
    ddr_data_t   req_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pwr_up_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            pwr_up_s: begin
                if (count_done) begin
                    next_state = precharge_s;
                end
            end
            precharge_s: begin
                if (count_done) begin
                    next_state = refresh_s;
                end
            end
            refresh_s: begin
                if (count_done) begin
                    next_state = idle_s;
                end
            end
            idle_s: begin
                if (cpu_rd) begin
                    next_state = act_read_s; // read wins over write
                end else if (cpu_wr) begin
                    next_state = act_write_s;
                end
            end
            act_read_s: begin
                if (count_done) begin
                    next_state = read_wait_s;
                end
            end
            read_wait_s: begin
                if (count_done) begin
                    next_state = read_s;
                end
            end
            read_s: begin
                next_state = idle_s;
            end
            act_write_s: begin
                if (count_done) begin
                    next_state = write_s;
                end
            end
            write_s: begin
                if (count_done) begin
                    next_state = idle_s;
                end
            end
            default: begin
                next_state = pwr_up_s;
            end
        endcase
    end

    always_comb begin
        case (next_state)
            precharge_s: entry_delay = delay_cnt_t'(`T_PRECHARGE);
            refresh_s:   entry_delay = delay_cnt_t'(`T_REFRESH);
            act_read_s:  entry_delay = delay_cnt_t'(`T_RCD);
            act_write_s: entry_delay = delay_cnt_t'(`T_RCD);
            read_wait_s: entry_delay = delay_cnt_t'(`T_CAS);
            write_s:     entry_delay = delay_cnt_t'(`T_WR);
            default:     entry_delay = '0;
        endcase
    end

    assign entering = (next_state != state) && (entry_delay != '0);
    assign ready    = (state == idle_s);
    assign accept   = ready && (cpu_rd || cpu_wr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_up_loaded <= 1'b0;
            count_start   <= 1'b0;
            count_value   <= '0;
            active        <= 1'b0;
            rd_valid      <= 1'b0;
            cpu_rdata     <= '0;
        end else begin
            count_start <= 1'b0;
            if (!pwr_up_loaded) begin
                // first cycle out of reset already belongs to the power-up wait
                pwr_up_loaded <= 1'b1;
                count_start   <= 1'b1;
                count_value   <= delay_cnt_t'(`T_PWR_UP - 1);
            end else if (entering) begin
                count_start <= 1'b1;
                count_value <= entry_delay;
            end
            active   <= accept;                 // row open pulse on entry to activate
            rd_valid <= (next_state == read_s);
            if (next_state == read_s) begin
                cpu_rdata <= ddr_read_data;     // column data valid on last wait cycle
            end
        end
    end

    // request held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            req_bank  <= cpu_bank;
            req_row   <= cpu_row;
            req_col   <= cpu_col;
            req_wdata <= cpu_wdata;
        end
    end

    assign ddr_read       = (state == read_wait_s);
    assign ddr_write      = (state == write_s);
    assign ddr_bank       = req_bank;
    assign ddr_row        = req_row;
    assign ddr_col        = req_col;
    assign ddr_write_data = req_wdata;

endmodule

//--- source/ddr_ctrl_macros.svh
`ifndef DDR_CTRL_MACROS_SVH
`define DDR_CTRL_MACROS_SVH

// address and data widths
`define DDR_BANK_W 4
`define DDR_ROW_W 16
`define DDR_COL_W 8
`define DDR_DATA_W 32

`define DDR_CNT_W 5 // wide enough for the longest wait

// delays in clock cycles
`define T_PWR_UP 15
`define T_PRECHARGE 10
`define T_REFRESH 7
`define T_RCD 3 // activate to column command
`define T_CAS 5
`define T_WR 5

// low address bits kept by the memory model
`define MEM_BANK_BITS 2
`define MEM_ROW_BITS 4

`endif

//--- source/ddr_ctrl_pkg.sv
`include "ddr_ctrl_macros.svh"

package ddr_ctrl_pkg;

    typedef logic [`DDR_BANK_W-1:0] bank_addr_t;
    typedef logic [`DDR_ROW_W-1:0] row_addr_t;
    typedef logic [`DDR_COL_W-1:0] col_addr_t;
    typedef logic [`DDR_DATA_W-1:0] ddr_data_t;
    typedef logic [`DDR_CNT_W-1:0] delay_cnt_t; // wait length in cycles

    // command sequencer states
    typedef enum logic [3:0] {
        pwr_up_s    = 4'd0,
        precharge_s = 4'd1,
        refresh_s   = 4'd2,
        idle_s      = 4'd3,
        act_read_s  = 4'd4,
        read_wait_s = 4'd5,
        read_s      = 4'd6,
        act_write_s = 4'd7,
        write_s     = 4'd8
    } ctrl_state_t;

endpackage

//--- source/ddr_ctrl_top.sv
`timescale 1ns/10ps
`include "ddr_ctrl_macros.svh"

module ddr_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cpu_rd,
    input  logic                     cpu_wr,
    input  ddr_ctrl_pkg::bank_addr_t cpu_bank,
    input  ddr_ctrl_pkg::row_addr_t  cpu_row,
    input  ddr_ctrl_pkg::col_addr_t  cpu_col,
    input  ddr_ctrl_pkg::ddr_data_t  cpu_wdata,
    output ddr_ctrl_pkg::ddr_data_t  cpu_rdata,
    output logic                     rd_valid,
    output logic                     ready
);
    import ddr_ctrl_pkg::*;

    logic       count_start;
    logic       count_done;
    delay_cnt_t count_value;
    logic       active;
    logic       ddr_read;
    logic       ddr_write;
    bank_addr_t ddr_bank;
    row_addr_t  ddr_row;
    col_addr_t  ddr_col;
    ddr_data_t  ddr_write_data;
    ddr_data_t  ddr_read_data;

    ddr_cmd_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_rd         (cpu_rd),
        .cpu_wr         (cpu_wr),
        .cpu_bank       (cpu_bank),
        .cpu_row        (cpu_row),
        .cpu_col        (cpu_col),
        .cpu_wdata      (cpu_wdata),
        .cpu_rdata      (cpu_rdata),
        .rd_valid       (rd_valid),
        .ready          (ready),
        .count_done     (count_done),
        .count_start    (count_start),
        .count_value    (count_value),
        .active         (active),
        .ddr_read       (ddr_read),
        .ddr_write      (ddr_write),
        .ddr_bank       (ddr_bank),
        .ddr_row        (ddr_row),
        .ddr_col        (ddr_col),
        .ddr_write_data (ddr_write_data),
        .ddr_read_data  (ddr_read_data)
    );

    ddr_delay_counter u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .count_start (count_start),
        .count_value (count_value),
        .count_done  (count_done)
    );

    ddr_bank_memory #(
        .BANK_BITS (`MEM_BANK_BITS),
        .ROW_BITS  (`MEM_ROW_BITS)
    ) u_memory (
        .clk            (clk),
        .active         (active),
        .ddr_bank       (ddr_bank),
        .ddr_row        (ddr_row),
        .ddr_col        (ddr_col),
        .ddr_read       (ddr_read),
        .ddr_write      (ddr_write),
        .ddr_write_data (ddr_write_data),
        .ddr_read_data  (ddr_read_data)
    );

endmodule

//--- source/ddr_delay_counter.sv
`timescale 1ns/10ps

module ddr_delay_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    count_start,
    input  ddr_ctrl_pkg::delay_cnt_t count_value,
    output logic                    count_done
);
    import ddr_ctrl_pkg::*;

    delay_cnt_t remaining; // cycles left after the current one, plus one

    // the load cycle is the first cycle of the wait
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (count_start) begin
            remaining <= count_value - delay_cnt_t'(1);
        end else if (remaining != '0) begin
            remaining <= remaining - delay_cnt_t'(1);
        end
    end

    assign count_done = (remaining == delay_cnt_t'(1)); // last cycle of the wait

endmodule
